/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
TOP       := tb_soc
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* clint/clint.sv */
module clint import soc_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rtc_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [ClintAddrBits-1:0] addr_i,
  input  data_t                    wdata_i,
  input  strb_t                    be_i,
  output data_t                    rdata_o,
  output logic                     timer_irq_o,
  output logic                     ipi_o
);

  localparam int unsigned WordBits = ClintAddrBits - ByteOffBits;

  logic [WordBits-1:0] word_sel;
  logic                sel_msip, sel_mtimecmp, sel_mtime;
  logic                wr_en;
  logic [1:0]          rtc_sync_q;
  logic                rtc_prev_q;
  logic                rtc_rise;
  logic                msip_q;
  data_t               mtimecmp_q;
  data_t               mtime_q;

  // ----------------------------------------
  // register select
  // ----------------------------------------
  assign word_sel     = addr_i[ClintAddrBits-1:ByteOffBits];
  assign sel_msip     = word_sel == ClintMsipOff[ClintAddrBits-1:ByteOffBits];
  assign sel_mtimecmp = word_sel == ClintMtimecmpOff[ClintAddrBits-1:ByteOffBits];
  assign sel_mtime    = word_sel == ClintMtimeOff[ClintAddrBits-1:ByteOffBits];
  assign wr_en        = req_i & we_i;

  // ----------------------------------------
  // rtc synchronizer and edge detect
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (wr_en && sel_msip && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (wr_en && sel_mtimecmp) begin
        mtimecmp_q <= apply_be(mtimecmp_q, wdata_i, be_i);
      end
      // a bus write wins over a tick in the same cycle
      if (wr_en && sel_mtime) begin
        mtime_q <= apply_be(mtime_q, wdata_i, be_i);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // read data only loads on a read strobe
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      if (sel_msip) begin
        rdata_o <= {{(DataWidth-1){1'b0}}, msip_q};
      end else if (sel_mtimecmp) begin
        rdata_o <= mtimecmp_q;
      end else if (sel_mtime) begin
        rdata_o <= mtime_q;
      end else begin
        rdata_o <= '0;
      end
    end
  end

  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

endmodule

/* common/soc_pkg.sv */
package soc_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 64;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned ByteOffBits = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // which block serves a request
  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_CLINT,
    TGT_NONE
  } target_e;

  // same codes as an AXI response
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  localparam addr_t RomBase     = 32'h0000_1000;
  localparam addr_t RomLength   = 32'h0000_0100;
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0000_C000;
  localparam addr_t SramBase    = 32'h8000_0000;

  localparam int unsigned RomWords      = RomLength / StrbWidth;
  localparam int unsigned RomAddrBits   = $clog2(RomWords);
  localparam int unsigned ClintAddrBits = 16;

  // clint register offsets
  localparam addr_t ClintMsipOff     = 32'h0000_0000;
  localparam addr_t ClintMtimecmpOff = 32'h0000_4000;
  localparam addr_t ClintMtimeOff    = 32'h0000_BFF8;

  // ----------------------------------------
  // rom contents and byte merging
  // ----------------------------------------
  localparam logic [31:0] RomTag = 32'hB007_C0DE;

  function automatic data_t rom_word(input int unsigned idx);
    return {RomTag, 32'(idx)};
  endfunction

  // replace only the bytes selected by be
  function automatic data_t apply_be(input data_t old_word, input data_t new_word,
                                     input strb_t be);
    data_t merged;
    merged = old_word;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  // interrupt vector bit positions
  localparam int unsigned IrqMsip = 3;
  localparam int unsigned IrqMtip = 7;
  localparam int unsigned IrqSeip = 9;
  localparam int unsigned IrqMeip = 11;

endpackage

/* compile.f */
common/soc_pkg.sv
src/bootrom.sv
src/sram.sv
clint/clint.sv
src/debug_gate.sv
src/bus_demux.sv
src/soc_top.sv
tests/tb_soc.sv

/* src/bootrom.sv */
module bootrom import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic [RomAddrBits-1:0] addr_i,
  output data_t                  rdata_o
);

  data_t rom_table [RomWords];

  // tag in the upper half, word index in the lower half
  for (genvar i = 0; i < RomWords; i++) begin : g_table
    assign rom_table[i] = rom_word(i);
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_table[addr_i];
    end
  end

endmodule

/* src/bus_demux.sv */
module bus_demux import soc_pkg::*; #(
  parameter int unsigned NumWords = 256
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  logic                          req_we_i,
  input  addr_t                         req_addr_i,
  input  data_t                         req_wdata_i,
  input  strb_t                         req_be_i,
  output logic                          resp_valid_o,
  input  logic                          resp_ready_i,
  output data_t                         resp_rdata_o,
  output resp_e                         resp_resp_o,
  output logic                          rom_req_o,
  output logic [RomAddrBits-1:0]        rom_addr_o,
  input  data_t                         rom_rdata_i,
  output logic                          sram_req_o,
  output logic                          sram_we_o,
  output logic [$clog2(NumWords)-1:0]   sram_addr_o,
  output data_t                         sram_wdata_o,
  output strb_t                         sram_be_o,
  input  data_t                         sram_rdata_i,
  output logic                          clint_req_o,
  output logic                          clint_we_o,
  output logic [ClintAddrBits-1:0]      clint_addr_o,
  output data_t                         clint_wdata_o,
  output strb_t                         clint_be_o,
  input  data_t                         clint_rdata_i
);

  localparam int unsigned SramAddrBits = $clog2(NumWords);
  localparam addr_t       SramLength   = addr_t'(NumWords * StrbWidth);

  logic    accept;
  logic    pending_q;
  target_e tgt;
  target_e rd_tgt_d, rd_tgt_q;
  resp_e   resp_d, resp_q;
  addr_t   rom_off, sram_off, clint_off;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  // offsets wrap below the base, so one compare per region is enough
  assign rom_off   = req_addr_i - RomBase;
  assign sram_off  = req_addr_i - SramBase;
  assign clint_off = req_addr_i - ClintBase;

  always_comb begin
    if (rom_off < RomLength) begin
      tgt = TGT_ROM;
    end else if (sram_off < SramLength) begin
      tgt = TGT_SRAM;
    end else if (clint_off < ClintLength) begin
      tgt = TGT_CLINT;
    end else begin
      tgt = TGT_NONE;
    end
  end

  assign resp_d = (tgt == TGT_NONE)             ? RESP_DECERR :
                  (tgt == TGT_ROM && req_we_i)  ? RESP_SLVERR : RESP_OKAY;

  // writes and errors return zero data
  assign rd_tgt_d = (resp_d != RESP_OKAY || req_we_i) ? TGT_NONE : tgt;

  assign accept = req_valid_i & req_ready_o;

  // ----------------------------------------
  // target strobes
  // ----------------------------------------
  assign rom_req_o  = accept && (tgt == TGT_ROM) && !req_we_i;
  assign rom_addr_o = rom_off[ByteOffBits +: RomAddrBits];

  assign sram_req_o   = accept && (tgt == TGT_SRAM);
  assign sram_we_o    = req_we_i;
  assign sram_addr_o  = sram_off[ByteOffBits +: SramAddrBits];
  assign sram_wdata_o = req_wdata_i;
  assign sram_be_o    = req_be_i;

  assign clint_req_o   = accept && (tgt == TGT_CLINT);
  assign clint_we_o    = req_we_i;
  assign clint_addr_o  = clint_off[ClintAddrBits-1:0];
  assign clint_wdata_o = req_wdata_i;
  assign clint_be_o    = req_be_i;

  // ----------------------------------------
  // response hold
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      rd_tgt_q  <= TGT_NONE;
      resp_q    <= RESP_OKAY;
    end else if (accept) begin
      pending_q <= 1'b1;
      rd_tgt_q  <= rd_tgt_d;
      resp_q    <= resp_d;
    end else if (resp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  assign req_ready_o  = ~pending_q;
  assign resp_valid_o = pending_q;
  assign resp_resp_o  = resp_q;

  always_comb begin
    case (rd_tgt_q)
      TGT_ROM:   resp_rdata_o = rom_rdata_i;
      TGT_SRAM:  resp_rdata_o = sram_rdata_i;
      TGT_CLINT: resp_rdata_o = clint_rdata_i;
      default:   resp_rdata_o = '0;
    endcase
  end

endmodule

/* src/debug_gate.sv */
module debug_gate #(
  parameter int unsigned DebugDelay = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned CntBits = (DebugDelay > 0) ? $clog2(DebugDelay + 1) : 1;

  logic [CntBits-1:0] cnt_q;

  // boot window countdown, stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntBits'(DebugDelay);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) & debug_en_i & debug_req_i;

endmodule

/* src/soc_top.sv */
module soc_top import soc_pkg::*; #(
  parameter int unsigned NumWords   = 256,
  parameter int unsigned DebugDelay = 500
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rtc_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  logic        req_we_i,
  input  addr_t       req_addr_i,
  input  data_t       req_wdata_i,
  input  strb_t       req_be_i,
  output logic        resp_valid_o,
  input  logic        resp_ready_i,
  output data_t       resp_rdata_o,
  output resp_e       resp_resp_o,
  input  logic [1:0]  ext_irq_i,
  output logic [63:0] irq_vec_o,
  input  logic        debug_req_i,
  input  logic        debug_en_i,
  output logic        debug_req_o
);

  localparam int unsigned SramAddrBits = $clog2(NumWords);

  logic                     rom_req;
  logic [RomAddrBits-1:0]   rom_addr;
  data_t                    rom_rdata;
  logic                     sram_req;
  logic                     sram_we;
  logic [SramAddrBits-1:0]  sram_addr;
  data_t                    sram_wdata;
  strb_t                    sram_be;
  data_t                    sram_rdata;
  logic                     clint_req;
  logic                     clint_we;
  logic [ClintAddrBits-1:0] clint_addr;
  data_t                    clint_wdata;
  strb_t                    clint_be;
  data_t                    clint_rdata;
  logic                     timer_irq;
  logic                     ipi;

  // ----------------------------------------
  // bus fabric and targets
  // ----------------------------------------
  bus_demux #(
    .NumWords ( NumWords )
  ) i_bus_demux (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_we_i, .req_addr_i, .req_wdata_i, .req_be_i,
    .resp_valid_o, .resp_ready_i, .resp_rdata_o, .resp_resp_o,
    .rom_req_o     ( rom_req     ),
    .rom_addr_o    ( rom_addr    ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_req_o    ( sram_req    ),
    .sram_we_o     ( sram_we     ),
    .sram_addr_o   ( sram_addr   ),
    .sram_wdata_o  ( sram_wdata  ),
    .sram_be_o     ( sram_be     ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_req_o   ( clint_req   ),
    .clint_we_o    ( clint_we    ),
    .clint_addr_o  ( clint_addr  ),
    .clint_wdata_o ( clint_wdata ),
    .clint_be_o    ( clint_be    ),
    .clint_rdata_i ( clint_rdata )
  );

  bootrom i_bootrom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

  sram #(
    .NumWords ( NumWords )
  ) i_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .addr_i  ( sram_addr  ),
    .wdata_i ( sram_wdata ),
    .be_i    ( sram_be    ),
    .rdata_o ( sram_rdata )
  );

  clint i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( clint_we    ),
    .addr_i      ( clint_addr  ),
    .wdata_i     ( clint_wdata ),
    .be_i        ( clint_be    ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq   ),
    .ipi_o       ( ipi         )
  );

  // ----------------------------------------
  // interrupts and debug
  // ----------------------------------------
  always_comb begin
    irq_vec_o          = '0;
    irq_vec_o[IrqMsip] = ipi;
    irq_vec_o[IrqMtip] = timer_irq;
    irq_vec_o[IrqSeip] = ext_irq_i[1];
    irq_vec_o[IrqMeip] = ext_irq_i[0];
  end

  debug_gate #(
    .DebugDelay ( DebugDelay )
  ) i_debug_gate (
    .clk_i, .rst_ni, .debug_req_i, .debug_en_i, .debug_req_o
  );

endmodule

/* src/sram.sv */
module sram import soc_pkg::*; #(
  parameter int unsigned NumWords = 256
) (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  data_t                       wdata_i,
  input  strb_t                       be_i,
  output data_t                       rdata_o
);

  data_t mem_q [NumWords];

  // memory starts out cleared in simulation
  initial begin
    for (int i = 0; i < NumWords; i++) begin
      mem_q[i] = '0;
    end
  end

  // ----------------------------------------
  // single port access
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= apply_be(mem_q[addr_i], wdata_i, be_i);
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

  // read data holds until the next read strobe

endmodule

/* tests/tb_soc.sv */
module tb_soc import soc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned WaitLimit = 30;
  localparam int unsigned RtcPulses = 5;

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t be;
    data_t exp_rdata;
    resp_e exp_resp;
    int    pulses;
    int    irq_bit;
    logic  irq_exp;
  } txn_t;

  logic        clk_i = 1'b0;
  logic        rst_ni, rtc_i;
  logic        req_valid_i, req_ready_o, req_we_i;
  addr_t       req_addr_i;
  data_t       req_wdata_i;
  strb_t       req_be_i;
  logic        resp_valid_o, resp_ready_i;
  data_t       resp_rdata_o;
  resp_e       resp_resp_o;
  logic [1:0]  ext_irq_i;
  logic [63:0] irq_vec_o;
  logic        debug_req_i, debug_en_i, debug_req_o;

  txn_t        txn_q[$];
  string       txn_names[$];
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          bad_tests = 0;
  int unsigned cycle_cnt = 0;
  int unsigned timeout_limit = 0;

  soc_top #(
    .NumWords   ( 256 ),
    .DebugDelay ( 40  )
  ) soc_top_i (.*);

  always #10 clk_i = ~clk_i;

  // run limit scales with the table
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_data(input string name, input data_t act, input data_t exp);
    if (act !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_resp(input string name, input resp_e act, input resp_e exp);
    if (act !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_vec(input string name, input logic [63:0] act,
                           input logic [63:0] exp);
    if (act !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    test_cnt++;
    if (err_cnt != errs_at_start) begin
      bad_tests++;
      $display("test %0d %s: failed", test_cnt, name);
    end else begin
      $display("test %0d %s: passed", test_cnt, name);
    end
  endtask

  // ----------------------------------------
  // expected value models
  // ----------------------------------------
  function automatic data_t rom_expect(input int unsigned idx);
    return (data_t'(RomTag) << 32) | data_t'(idx);
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t be);
    data_t mask;
    mask = '0;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) mask[8*b +: 8] = 8'hFF;
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic logic random_ready();
    return ($urandom() % 3) != 0;
  endfunction

  function automatic void add_txn(input string name, input logic we, input addr_t addr,
                                  input data_t wdata, input strb_t be, input data_t exp_rdata,
                                  input resp_e exp_resp, input int pulses, input int irq_bit,
                                  input logic irq_exp);
    txn_t t;
    t = '{we, addr, wdata, be, exp_rdata, exp_resp, pulses, irq_bit, irq_exp};
    txn_q.push_back(t);
    txn_names.push_back(name);
  endfunction

  function automatic void add_read(input string name, input addr_t addr, input data_t exp_rdata,
                                   input resp_e exp_resp);
    add_txn(name, 1'b0, addr, '0, '1, exp_rdata, exp_resp, 0, -1, 1'b0);
  endfunction

  function automatic void add_write(input string name, input addr_t addr, input data_t wdata,
                                    input strb_t be, input resp_e exp_resp);
    add_txn(name, 1'b1, addr, wdata, be, '0, exp_resp, 0, -1, 1'b0);
  endfunction

  // ----------------------------------------
  // bus driver
  // ----------------------------------------
  task automatic pulse_rtc(input int count);
    repeat (count) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (4) @(posedge clk_i);
    end
  endtask

  task automatic run_txn(input int idx);
    txn_t  t;
    data_t held_data;
    resp_e held_resp;
    logic  seen;
    logic  done;
    int    waits;
    int    errs_at_start;
    t = txn_q[idx];
    errs_at_start = err_cnt;
    held_data = '0;
    held_resp = RESP_OKAY;
    seen = 1'b0;
    done = 1'b0;
    waits = 0;
    if (t.pulses != 0) pulse_rtc(t.pulses);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_we_i    <= t.we;
    req_addr_i  <= t.addr;
    req_wdata_i <= t.wdata;
    req_be_i    <= t.be;
    @(negedge clk_i);
    while (!req_ready_o && waits < WaitLimit) begin
      @(negedge clk_i);
      waits++;
    end
    if (!req_ready_o) begin
      $display("request of test %0d was never accepted", idx);
      err_cnt++;
    end
    @(posedge clk_i);
    req_valid_i  <= 1'b0;
    resp_ready_i <= random_ready();
    waits = 0;
    // response must hold its value while stalled
    while (!done && waits < WaitLimit) begin
      @(negedge clk_i);
      if (waits == 0) begin
        // one cycle from acceptance to response
        check_bit("resp_valid_o", resp_valid_o, 1'b1);
      end
      if (resp_valid_o) begin
        if (!seen) begin
          held_data = resp_rdata_o;
          held_resp = resp_resp_o;
          seen = 1'b1;
        end else begin
          check_data("resp_rdata_o", resp_rdata_o, held_data);
          check_resp("resp_resp_o", resp_resp_o, held_resp);
        end
        done = resp_ready_i;
      end
      @(posedge clk_i);
      resp_ready_i <= done ? 1'b0 : random_ready();
      waits++;
    end
    if (!done) begin
      $display("no response arrived for test %0d within %0d cycles", idx, WaitLimit);
      err_cnt++;
    end else begin
      check_data("resp_rdata_o", held_data, t.exp_rdata);
      check_resp("resp_resp_o", held_resp, t.exp_resp);
      // a second valid cycle would be a duplicate
      @(negedge clk_i);
      check_bit("resp_valid_o", resp_valid_o, 1'b0);
      if (t.irq_bit >= 0) begin
        check_bit($sformatf("irq_vec_o[%0d]", t.irq_bit), irq_vec_o[t.irq_bit], t.irq_exp);
      end
    end
    report_test(txn_names[idx], errs_at_start);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    data_t merged;
    int    errs;
    void'($urandom(95940));
    rst_ni = 1'b0;
    rtc_i = 1'b0;
    req_valid_i = 1'b0;
    req_we_i = 1'b0;
    req_addr_i = '0;
    req_wdata_i = '0;
    req_be_i = '0;
    resp_ready_i = 1'b0;
    ext_irq_i = 2'b00;
    debug_req_i = 1'b1;
    debug_en_i = 1'b1;

    add_read("rom word 0", RomBase, rom_expect(0), RESP_OKAY);
    add_read("rom word 5", RomBase + 32'h28, rom_expect(5), RESP_OKAY);
    add_read("rom word 31", RomBase + 32'hF8, rom_expect(31), RESP_OKAY);
    add_write("rom write", RomBase + 32'h10, 64'hDEAD_BEEF, '1, RESP_SLVERR);
    add_write("sram write low", SramBase, 64'h0123_4567_89AB_CDEF, '1, RESP_OKAY);
    add_write("sram write top", SramBase + 32'h7F8, 64'hFEDC_BA98_7654_3210, '1, RESP_OKAY);
    add_read("sram read low", SramBase, 64'h0123_4567_89AB_CDEF, RESP_OKAY);
    add_read("sram read top", SramBase + 32'h7F8, 64'hFEDC_BA98_7654_3210, RESP_OKAY);
    merged = 64'h1111_2222_3333_4444;
    add_write("sram base word", SramBase + 32'h40, merged, '1, RESP_OKAY);
    add_write("sram partial a5", SramBase + 32'h40, 64'hAAAA_BBBB_CCCC_DDDD, 8'hA5, RESP_OKAY);
    merged = merge_bytes(merged, 64'hAAAA_BBBB_CCCC_DDDD, 8'hA5);
    add_read("sram merged a5", SramBase + 32'h40, merged, RESP_OKAY);
    add_write("sram partial 0f", SramBase + 32'h40, 64'h5566_7788_99AA_BBCC, 8'h0F, RESP_OKAY);
    merged = merge_bytes(merged, 64'h5566_7788_99AA_BBCC, 8'h0F);
    add_read("sram merged 0f", SramBase + 32'h40, merged, RESP_OKAY);
    add_read("unmapped read", 32'h0000_0F00, '0, RESP_DECERR);
    add_write("unmapped write", 32'h4000_0000, 64'h1, '1, RESP_DECERR);
    add_read("past sram end", SramBase + 32'h800, '0, RESP_DECERR);
    add_txn("msip set", 1'b1, ClintBase + ClintMsipOff, 64'h1, 8'h01, '0, RESP_OKAY,
            0, IrqMsip, 1'b1);
    add_read("msip read", ClintBase + ClintMsipOff, 64'h1, RESP_OKAY);
    add_txn("msip clear", 1'b1, ClintBase + ClintMsipOff, 64'h0, 8'h01, '0, RESP_OKAY,
            0, IrqMsip, 1'b0);
    add_read("clint unknown offset", ClintBase + 32'h100, '0, RESP_OKAY);
    add_txn("mtime after rtc", 1'b0, ClintBase + ClintMtimeOff, '0, '1, data_t'(RtcPulses),
            RESP_OKAY, RtcPulses, IrqMtip, 1'b0);
    add_txn("mtimecmp at mtime", 1'b1, ClintBase + ClintMtimecmpOff, data_t'(RtcPulses), '1,
            '0, RESP_OKAY, 0, IrqMtip, 1'b1);
    add_txn("mtimecmp above", 1'b1, ClintBase + ClintMtimecmpOff, data_t'(RtcPulses + 1), '1,
            '0, RESP_OKAY, 0, IrqMtip, 1'b0);
    add_read("mtimecmp read", ClintBase + ClintMtimecmpOff, data_t'(RtcPulses + 1), RESP_OKAY);
    timeout_limit = txn_q.size() * 40 + 400;

    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    errs = err_cnt;
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("resp_valid_o", resp_valid_o, 1'b0);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    report_test("reset state", errs);

    // boot window of the debug gate
    errs = err_cnt;
    for (int cyc = 1; cyc <= 50; cyc++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      if (cyc <= 30) begin
        check_bit("debug_req_o", debug_req_o, 1'b0);
      end else if (cyc >= 45) begin
        check_bit("debug_req_o", debug_req_o, 1'b1);
      end
    end
    report_test("debug boot window", errs);

    // after the window the output follows the request
    errs = err_cnt;
    @(posedge clk_i);
    debug_req_i <= 1'b0;
    @(negedge clk_i);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    @(posedge clk_i);
    debug_req_i <= 1'b1;
    @(negedge clk_i);
    check_bit("debug_req_o", debug_req_o, 1'b1);
    report_test("debug request passes", errs);

    errs = err_cnt;
    @(posedge clk_i);
    debug_en_i <= 1'b0;
    repeat (5) begin
      @(negedge clk_i);
      check_bit("debug_req_o", debug_req_o, 1'b0);
    end
    report_test("debug disabled", errs);

    for (int n = 0; n < txn_q.size(); n++) begin
      run_txn(n);
    end

    // msip and mtip are both clear here
    errs = err_cnt;
    @(posedge clk_i);
    ext_irq_i <= 2'b01;
    @(negedge clk_i);
    check_bit("irq_vec_o[11]", irq_vec_o[IrqMeip], 1'b1);
    check_bit("irq_vec_o[9]", irq_vec_o[IrqSeip], 1'b0);
    check_vec("irq_vec_o", irq_vec_o, 64'h0000_0000_0000_0800);
    @(posedge clk_i);
    ext_irq_i <= 2'b10;
    @(negedge clk_i);
    check_bit("irq_vec_o[11]", irq_vec_o[IrqMeip], 1'b0);
    check_bit("irq_vec_o[9]", irq_vec_o[IrqSeip], 1'b1);
    check_vec("irq_vec_o", irq_vec_o, 64'h0000_0000_0000_0200);
    report_test("external interrupts", errs);

    $display("%0d tests, %0d failed, %0d errors", test_cnt, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
